// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := controlUnitTb
FILELIST  := vlog.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(filter-out +incdir+%,$(shell cat $(FILELIST))) hdl/controlUnit_defs.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== hdl/controlUnit.sv ====
// Multicycle control unit
`timescale 1ns/1ps
`default_nettype none

module controlUnit
    import isaPkg::*;
    import ctrlPkg::*;
(
    input  wire logic    Clock,
    input  wire logic    rstN,
    input  wire opcode_t opcode,
    input  wire funct_t  funct,
    input  wire logic    overflow,
    input  wire logic    equal,
    input  wire logic    greater,
    input  wire logic    less,
    output logic         pcWrite,
    output logic         memWrite,
    output logic         irWrite,
    output logic         mdrWrite,
    output logic         regWrite,
    output logic         abWrite,
    output logic         aluOutWrite,
    output logic         epcWrite,
    output pcSource_t    pcSource,
    output memAddrSrc_t  memAddrSrc,
    output regDst_t      regDst,
    output regDataSrc_t  regDataSrc,
    output aluOp_t       aluOp,
    output aluSrcA_t     aluSrcA,
    output aluSrcB_t     aluSrcB
);

    instrClass_t instrClass;
    logic        excStart;
    excCause_t   excCause;
    excStep_t    excStep;
    memAddrSrc_t excAddrSrc;

    instrDecoder i_instrDecoder (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    mainSequencer i_mainSequencer (
        .Clock       (Clock),
        .rstN        (rstN),
        .instrClass  (instrClass),
        .overflow    (overflow),
        .equal       (equal),
        .greater     (greater),
        .less        (less),
        .excStep     (excStep),
        .excAddrSrc  (excAddrSrc),
        .excStart    (excStart),
        .excCause    (excCause),
        .pcWrite     (pcWrite),
        .memWrite    (memWrite),
        .irWrite     (irWrite),
        .mdrWrite    (mdrWrite),
        .regWrite    (regWrite),
        .abWrite     (abWrite),
        .aluOutWrite (aluOutWrite),
        .epcWrite    (epcWrite),
        .pcSource    (pcSource),
        .memAddrSrc  (memAddrSrc),
        .regDst      (regDst),
        .regDataSrc  (regDataSrc),
        .aluOp       (aluOp),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB)
    );

    exceptionSequencer i_exceptionSequencer (
        .Clock      (Clock),
        .rstN       (rstN),
        .excStart   (excStart),
        .excCause   (excCause),
        .excStep    (excStep),
        .excAddrSrc (excAddrSrc)
    );

endmodule

`default_nettype wire

// ==== hdl/controlUnit_defs.svh ====
// Control unit definitions
`ifndef CONTROLUNIT_DEFS_SVH
`define CONTROLUNIT_DEFS_SVH

// Instruction field widths
`define OPCODE_W 6
`define FUNCT_W 6

// Opcodes
`define OP_RTYPE 6'h00
`define OP_J 6'h02
`define OP_JAL 6'h03
`define OP_BEQ 6'h04
`define OP_BNE 6'h05
`define OP_BLE 6'h06
`define OP_BGT 6'h07
`define OP_ADDI 6'h08
`define OP_ADDIU 6'h09
`define OP_LW 6'h23
`define OP_SW 6'h2b

// R-type function codes
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_SLT 6'h2a

// Cycles a memory read is held before data is valid
`define MEM_WAIT 2

`endif

// ==== hdl/ctrlPkg.sv ====
// Datapath control types
`default_nettype none
`include "controlUnit_defs.svh"

package ctrlPkg;

    typedef enum logic [2:0] {
        pcAluResult, pcJumpTarget, pcBranchTarget, pcExcVector
    } pcSource_t;

    typedef enum logic [2:0] {
        memPc, memAluOut, memUndefVector, memOvfVector
    } memAddrSrc_t;

    typedef enum logic [1:0] {dstRt, dstRd, dstRa, dstSp} regDst_t;

    typedef enum logic [2:0] {
        dataAluOut, dataMdr, dataLessThan, dataStackInit
    } regDataSrc_t;

    typedef enum logic [2:0] {
        aluPass, aluAdd, aluSub, aluAnd, aluCompare
    } aluOp_t;

    typedef enum logic [1:0] {srcAPc, srcARegA} aluSrcA_t;

    typedef enum logic [1:0] {srcBRegB, srcBFour, srcBImm, srcBBranchOff} aluSrcB_t;

    // Memory wait counter
    typedef logic [$clog2(`MEM_WAIT + 1)-1:0] waitCount_t;

    typedef enum logic [4:0] {
        stReset, stResetWrite,
        stFetch, stInstrWait, stIrLoad, stRegRead, stDispatch,
        stExecute, stWriteBack,
        stCompare, stBranchTaken,
        stJump, stJalLink, stJalWrite,
        stMemAddr, stMemWait, stMdrLoad, stLoadWrite, stStore,
        stExcWait
    } seqState_t;

    typedef enum logic [2:0] {
        excIdle, excSaveEpc, excReadVector, excLoadMdr, excJump
    } excStep_t;

    typedef enum logic {causeOverflow, causeUndefined} excCause_t;

endpackage

`default_nettype wire

// ==== hdl/exceptionSequencer.sv ====
// Exception sequencer
`timescale 1ns/1ps
`default_nettype none
`include "controlUnit_defs.svh"

module exceptionSequencer
    import ctrlPkg::*;
(
    input  wire logic      Clock,
    input  wire logic      rstN,
    input  wire logic      excStart,
    input  wire excCause_t excCause,
    output excStep_t       excStep,
    output memAddrSrc_t    excAddrSrc
);

    waitCount_t waitCount;
    logic       waitDone;
    excCause_t  causeReg;

    assign waitDone = (waitCount == waitCount_t'(`MEM_WAIT - 1));

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            excStep <= excIdle;
            waitCount <= '0;
        end else begin
            case (excStep)
                excIdle: begin
                    if (excStart) begin
                        excStep <= excSaveEpc;
                    end
                end
                excSaveEpc: begin
                    excStep <= excReadVector;
                    waitCount <= '0;
                end
                excReadVector: begin
                    if (waitDone) begin
                        excStep <= excLoadMdr;
                    end else begin
                        waitCount <= waitCount + 1'b1;
                    end
                end
                excLoadMdr: excStep <= excJump;
                default: excStep <= excIdle;
            endcase
        end
    end

    // Cause captured at entry
    always_ff @(posedge Clock) begin
        if (excStart) begin
            causeReg <= excCause;
        end
    end

    assign excAddrSrc = (causeReg == causeUndefined) ? memUndefVector : memOvfVector;

endmodule

`default_nettype wire

// ==== hdl/instrDecoder.sv ====
// Instruction decoder
`timescale 1ns/1ps
`default_nettype none
`include "controlUnit_defs.svh"

module instrDecoder
    import isaPkg::*;
(
    input  wire opcode_t     opcode,
    input  wire funct_t      funct,
    output instrClass_t      instrClass
);

    always_comb begin
        case (opcode)
            `OP_RTYPE: begin
                // Function field only matters for R-type
                case (funct)
                    `FN_ADD: instrClass = clsAdd;
                    `FN_SUB: instrClass = clsSub;
                    `FN_AND: instrClass = clsAnd;
                    `FN_SLT: instrClass = clsSlt;
                    default: instrClass = clsUndefined;
                endcase
            end
            `OP_J: instrClass = clsJ;
            `OP_JAL: instrClass = clsJal;
            `OP_BEQ: instrClass = clsBeq;
            `OP_BNE: instrClass = clsBne;
            `OP_BLE: instrClass = clsBle;
            `OP_BGT: instrClass = clsBgt;
            `OP_ADDI: instrClass = clsAddi;
            `OP_ADDIU: instrClass = clsAddiu;
            `OP_LW: instrClass = clsLw;
            `OP_SW: instrClass = clsSw;
            default: instrClass = clsUndefined;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/isaPkg.sv ====
// Instruction set types
`default_nettype none
`include "controlUnit_defs.svh"

package isaPkg;

    typedef logic [`OPCODE_W-1:0] opcode_t;
    typedef logic [`FUNCT_W-1:0] funct_t;

    // One class per supported instruction
    typedef enum logic [3:0] {
        clsAdd,
        clsSub,
        clsAnd,
        clsSlt,
        clsAddi,
        clsAddiu,
        clsBeq,
        clsBne,
        clsBle,
        clsBgt,
        clsJ,
        clsJal,
        clsLw,
        clsSw,
        clsUndefined
    } instrClass_t;

endpackage

`default_nettype wire

// ==== hdl/mainSequencer.sv ====
// Main control sequencer
`timescale 1ns/1ps
`default_nettype none
`include "controlUnit_defs.svh"

module mainSequencer
    import isaPkg::*;
    import ctrlPkg::*;
(
    input  wire logic        Clock,
    input  wire logic        rstN,
    input  wire instrClass_t instrClass,
    input  wire logic        overflow,
    input  wire logic        equal,
    input  wire logic        greater,
    input  wire logic        less,
    input  wire excStep_t    excStep,
    input  wire memAddrSrc_t excAddrSrc,
    output logic             excStart,
    output excCause_t        excCause,
    output logic             pcWrite,
    output logic             memWrite,
    output logic             irWrite,
    output logic             mdrWrite,
    output logic             regWrite,
    output logic             abWrite,
    output logic             aluOutWrite,
    output logic             epcWrite,
    output pcSource_t        pcSource,
    output memAddrSrc_t      memAddrSrc,
    output regDst_t          regDst,
    output regDataSrc_t      regDataSrc,
    output aluOp_t           aluOp,
    output aluSrcA_t         aluSrcA,
    output aluSrcB_t         aluSrcB
);

    seqState_t  state;
    seqState_t  nextState;
    waitCount_t waitCount;
    logic       waitDone;
    logic       takeBranch;
    logic       ovfTrap;
    logic       rType;

    assign waitDone = (waitCount == waitCount_t'(`MEM_WAIT - 1));
    assign rType = instrClass inside {clsAdd, clsSub, clsAnd, clsSlt};
    // and and addiu never trap
    assign ovfTrap = overflow && (instrClass inside {clsAdd, clsSub, clsAddi});

    always_comb begin
        case (instrClass)
            clsBeq: takeBranch = equal;
            clsBne: takeBranch = !equal;
            clsBle: takeBranch = equal || less;
            clsBgt: takeBranch = greater;
            default: takeBranch = 1'b0;
        endcase
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            state <= stReset;
            waitCount <= '0;
        end else begin
            state <= nextState;
            if (state == stMemWait) begin
                waitCount <= waitCount + 1'b1;
            end else begin
                waitCount <= '0;
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            stReset: nextState = stResetWrite;
            stResetWrite: nextState = stFetch;
            stFetch: nextState = stInstrWait;
            stInstrWait: nextState = stIrLoad;
            stIrLoad: nextState = stRegRead;
            stRegRead: nextState = stDispatch;
            stDispatch: begin
                case (instrClass)
                    clsAdd, clsSub, clsAnd, clsSlt, clsAddi, clsAddiu: nextState = stExecute;
                    clsBeq, clsBne, clsBle, clsBgt: nextState = stCompare;
                    clsJ: nextState = stJump;
                    clsJal: nextState = stJalLink;
                    clsLw, clsSw: nextState = stMemAddr;
                    default: nextState = stExcWait;
                endcase
            end
            stExecute: begin
                if (instrClass == clsSlt) begin
                    nextState = stFetch;
                end else if (ovfTrap) begin
                    nextState = stExcWait;
                end else begin
                    nextState = stWriteBack;
                end
            end
            stCompare: nextState = takeBranch ? stBranchTaken : stFetch;
            stJalLink: nextState = stJalWrite;
            stMemAddr: nextState = (instrClass == clsLw) ? stMemWait : stStore;
            stMemWait: nextState = waitDone ? stMdrLoad : stMemWait;
            stMdrLoad: nextState = stLoadWrite;
            // Leave together with the last exception step
            stExcWait: nextState = (excStep == excJump) ? stFetch : stExcWait;
            default: nextState = stFetch;
        endcase
    end

    always_comb begin
        pcWrite = 1'b0;
        memWrite = 1'b0;
        irWrite = 1'b0;
        mdrWrite = 1'b0;
        regWrite = 1'b0;
        abWrite = 1'b0;
        aluOutWrite = 1'b0;
        epcWrite = 1'b0;
        excStart = 1'b0;
        excCause = causeOverflow;
        pcSource = pcAluResult;
        memAddrSrc = memPc;
        regDst = dstRt;
        regDataSrc = dataAluOut;
        aluOp = aluPass;
        aluSrcA = srcAPc;
        aluSrcB = srcBRegB;
        case (state)
            stResetWrite: begin
                regWrite = 1'b1;
                regDst = dstSp;
                regDataSrc = dataStackInit;
            end
            stFetch: begin
                // PC plus four
                pcWrite = 1'b1;
                aluOp = aluAdd;
                aluSrcB = srcBFour;
            end
            stIrLoad: irWrite = 1'b1;
            stRegRead: begin
                // Branch target computed ahead into ALUOut
                abWrite = 1'b1;
                aluOutWrite = 1'b1;
                aluOp = aluAdd;
                aluSrcB = srcBBranchOff;
            end
            stDispatch: begin
                if (instrClass == clsUndefined) begin
                    excStart = 1'b1;
                    excCause = causeUndefined;
                end
            end
            stExecute: begin
                aluSrcA = srcARegA;
                aluSrcB = rType ? srcBRegB : srcBImm;
                case (instrClass)
                    clsSub: aluOp = aluSub;
                    clsAnd: aluOp = aluAnd;
                    clsSlt: aluOp = aluCompare;
                    default: aluOp = aluAdd;
                endcase
                if (instrClass == clsSlt) begin
                    regWrite = 1'b1;
                    regDst = dstRd;
                    regDataSrc = dataLessThan;
                end else begin
                    aluOutWrite = 1'b1;
                    excStart = ovfTrap;
                end
            end
            stWriteBack: begin
                regWrite = 1'b1;
                regDst = rType ? dstRd : dstRt;
            end
            stCompare: begin
                aluOp = aluCompare;
                aluSrcA = srcARegA;
            end
            stBranchTaken: begin
                pcWrite = 1'b1;
                pcSource = pcBranchTarget;
            end
            stJump: begin
                pcWrite = 1'b1;
                pcSource = pcJumpTarget;
            end
            // Return address into ALUOut
            stJalLink: aluOutWrite = 1'b1;
            stJalWrite: begin
                pcWrite = 1'b1;
                pcSource = pcJumpTarget;
                regWrite = 1'b1;
                regDst = dstRa;
            end
            stMemAddr: begin
                aluOutWrite = 1'b1;
                aluOp = aluAdd;
                aluSrcA = srcARegA;
                aluSrcB = srcBImm;
            end
            stMemWait: memAddrSrc = memAluOut;
            stMdrLoad: begin
                mdrWrite = 1'b1;
                memAddrSrc = memAluOut;
            end
            stLoadWrite: begin
                regWrite = 1'b1;
                regDataSrc = dataMdr;
            end
            stStore: begin
                memWrite = 1'b1;
                memAddrSrc = memAluOut;
            end
            stExcWait: begin
                case (excStep)
                    excSaveEpc: begin
                        // EPC gets the faulting PC
                        epcWrite = 1'b1;
                        aluOp = aluSub;
                        aluSrcB = srcBFour;
                    end
                    excReadVector: memAddrSrc = excAddrSrc;
                    excLoadMdr: begin
                        mdrWrite = 1'b1;
                        memAddrSrc = excAddrSrc;
                    end
                    excJump: begin
                        pcWrite = 1'b1;
                        pcSource = pcExcVector;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== test/controlUnitTb.sv ====
// Control unit testbench
`timescale 1ns/1ps
`default_nettype none
`include "controlUnit_defs.svh"

module controlUnitTb
    import isaPkg::*;
    import ctrlPkg::*;
();

    localparam int NUM_INSTR = 33;
    // Longest path is an overflow trap
    localparam int CYCLE_LIMIT = NUM_INSTR * (9 + `MEM_WAIT) + 40;

    logic        Clock;
    logic        rstN;
    opcode_t     opcode;
    funct_t      funct;
    logic        overflow;
    logic        equal;
    logic        greater;
    logic        less;
    logic        pcWrite;
    logic        memWrite;
    logic        irWrite;
    logic        mdrWrite;
    logic        regWrite;
    logic        abWrite;
    logic        aluOutWrite;
    logic        epcWrite;
    pcSource_t   pcSource;
    memAddrSrc_t memAddrSrc;
    regDst_t     regDst;
    regDataSrc_t regDataSrc;
    aluOp_t      aluOp;
    aluSrcA_t    aluSrcA;
    aluSrcB_t    aluSrcB;

    int     errorCount;
    int     checkCount;
    int     cycleCount;
    integer seed;

    controlUnit i_controlUnit (
        .Clock       (Clock),
        .rstN        (rstN),
        .opcode      (opcode),
        .funct       (funct),
        .overflow    (overflow),
        .equal       (equal),
        .greater     (greater),
        .less        (less),
        .pcWrite     (pcWrite),
        .memWrite    (memWrite),
        .irWrite     (irWrite),
        .mdrWrite    (mdrWrite),
        .regWrite    (regWrite),
        .abWrite     (abWrite),
        .aluOutWrite (aluOutWrite),
        .epcWrite    (epcWrite),
        .pcSource    (pcSource),
        .memAddrSrc  (memAddrSrc),
        .regDst      (regDst),
        .regDataSrc  (regDataSrc),
        .aluOp       (aluOp),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB)
    );

    bind controlUnit controlUnitProps i_controlUnitProps (
        .Clock    (Clock),
        .rstN     (rstN),
        .memWrite (memWrite),
        .mdrWrite (mdrWrite),
        .irWrite  (irWrite),
        .pcWrite  (pcWrite),
        .regWrite (regWrite)
    );

    always #10 Clock = ~Clock;

    always @(posedge Clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic compareBit(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic comparePcSource(input pcSource_t got, input pcSource_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Error: pcSource = 0x%h, expected 0x%h at %0t", got, exp, $time);
        end
    endtask

    task automatic compareMemAddr(input memAddrSrc_t got, input memAddrSrc_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Error: memAddrSrc = 0x%h, expected 0x%h at %0t", got, exp, $time);
        end
    endtask

    task automatic compareRegDst(input regDst_t got, input regDst_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Error: regDst = 0x%h, expected 0x%h at %0t", got, exp, $time);
        end
    endtask

    task automatic compareRegData(input regDataSrc_t got, input regDataSrc_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Error: regDataSrc = 0x%h, expected 0x%h at %0t", got, exp, $time);
        end
    endtask

    task automatic compareAluOp(input aluOp_t got, input aluOp_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Error: aluOp = 0x%h, expected 0x%h at %0t", got, exp, $time);
        end
    endtask

    task automatic compareAluSrcA(input aluSrcA_t got, input aluSrcA_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Error: aluSrcA = 0x%h, expected 0x%h at %0t", got, exp, $time);
        end
    endtask

    task automatic compareAluSrcB(input aluSrcB_t got, input aluSrcB_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Error: aluSrcB = 0x%h, expected 0x%h at %0t", got, exp, $time);
        end
    endtask

    // Sample point in the middle of the next cycle
    task automatic nextCycle();
        @(negedge Clock);
    endtask

    task automatic resetOutputsIdle();
        compareBit("pcWrite", pcWrite, 1'b0);
        compareBit("memWrite", memWrite, 1'b0);
        compareBit("irWrite", irWrite, 1'b0);
        compareBit("mdrWrite", mdrWrite, 1'b0);
        compareBit("regWrite", regWrite, 1'b0);
        compareBit("abWrite", abWrite, 1'b0);
        compareBit("aluOutWrite", aluOutWrite, 1'b0);
        compareBit("epcWrite", epcWrite, 1'b0);
        comparePcSource(pcSource, pcAluResult);
        compareMemAddr(memAddrSrc, memPc);
        compareRegDst(regDst, dstRt);
        compareRegData(regDataSrc, dataAluOut);
        compareAluOp(aluOp, aluPass);
        compareAluSrcA(aluSrcA, srcAPc);
        compareAluSrcB(aluSrcB, srcBRegB);
    endtask

    task automatic checkFetch();
        compareBit("pcWrite", pcWrite, 1'b1);
        comparePcSource(pcSource, pcAluResult);
        compareMemAddr(memAddrSrc, memPc);
        compareAluOp(aluOp, aluAdd);
        compareAluSrcA(aluSrcA, srcAPc);
        compareAluSrcB(aluSrcB, srcBFour);
        compareBit("irWrite", irWrite, 1'b0);
        compareBit("regWrite", regWrite, 1'b0);
        compareBit("memWrite", memWrite, 1'b0);
    endtask

    // Drives one instruction and walks fetch to dispatch
    task automatic fetchPhase(input opcode_t op, input funct_t fn, input logic ovf,
                              input logic eq, input logic gt, input logic lt);
        @(posedge Clock);
        #2;
        opcode = op;
        funct = fn;
        overflow = ovf;
        equal = eq;
        greater = gt;
        less = lt;
        @(negedge Clock);
        checkFetch();
        nextCycle();
        compareBit("pcWrite", pcWrite, 1'b0);
        compareBit("irWrite", irWrite, 1'b0);
        nextCycle();
        compareBit("irWrite", irWrite, 1'b1);
        nextCycle();
        compareBit("irWrite", irWrite, 1'b0);
        compareBit("abWrite", abWrite, 1'b1);
        compareBit("aluOutWrite", aluOutWrite, 1'b1);
        compareAluOp(aluOp, aluAdd);
        compareAluSrcA(aluSrcA, srcAPc);
        compareAluSrcB(aluSrcB, srcBBranchOff);
        nextCycle();
        compareBit("pcWrite", pcWrite, 1'b0);
        compareBit("regWrite", regWrite, 1'b0);
        compareBit("memWrite", memWrite, 1'b0);
    endtask

    task automatic runArith(input opcode_t op, input funct_t fn, input logic ovf);
        fetchPhase(op, fn, ovf, 1'b0, 1'b0, 1'b0);
        nextCycle();
        compareBit("memWrite", memWrite, 1'b0);
        compareAluSrcA(aluSrcA, srcARegA);
        compareAluSrcB(aluSrcB, (op == `OP_RTYPE) ? srcBRegB : srcBImm);
        if (op == `OP_RTYPE && fn == `FN_SLT) begin
            compareBit("regWrite", regWrite, 1'b1);
            compareRegDst(regDst, dstRd);
            compareRegData(regDataSrc, dataLessThan);
        end else begin
            compareBit("regWrite", regWrite, 1'b0);
            compareBit("aluOutWrite", aluOutWrite, 1'b1);
            nextCycle();
            compareBit("regWrite", regWrite, 1'b1);
            compareRegDst(regDst, (op == `OP_RTYPE) ? dstRd : dstRt);
            compareRegData(regDataSrc, dataAluOut);
            compareBit("memWrite", memWrite, 1'b0);
        end
    endtask

    // EPC save, vector read, MDR load, jump
    task automatic exceptionSteps(input memAddrSrc_t vector);
        nextCycle();
        compareBit("epcWrite", epcWrite, 1'b1);
        compareBit("regWrite", regWrite, 1'b0);
        compareAluOp(aluOp, aluSub);
        compareAluSrcA(aluSrcA, srcAPc);
        compareAluSrcB(aluSrcB, srcBFour);
        repeat (`MEM_WAIT) begin
            nextCycle();
            compareMemAddr(memAddrSrc, vector);
            compareBit("mdrWrite", mdrWrite, 1'b0);
            compareBit("regWrite", regWrite, 1'b0);
        end
        nextCycle();
        compareBit("mdrWrite", mdrWrite, 1'b1);
        compareBit("regWrite", regWrite, 1'b0);
        nextCycle();
        compareBit("pcWrite", pcWrite, 1'b1);
        comparePcSource(pcSource, pcExcVector);
        compareBit("regWrite", regWrite, 1'b0);
    endtask

    task automatic runOverflow(input opcode_t op, input funct_t fn);
        fetchPhase(op, fn, 1'b1, 1'b0, 1'b0, 1'b0);
        nextCycle();
        compareBit("regWrite", regWrite, 1'b0);
        exceptionSteps(memOvfVector);
    endtask

    task automatic runUndefined(input opcode_t op, input funct_t fn);
        fetchPhase(op, fn, 1'b0, 1'b0, 1'b0, 1'b0);
        exceptionSteps(memUndefVector);
    endtask

    function automatic logic branchExpected(input opcode_t op, input logic eq,
                                            input logic gt, input logic lt);
        case (op)
            `OP_BEQ: return eq;
            `OP_BNE: return !eq;
            `OP_BLE: return eq || lt;
            `OP_BGT: return gt;
            default: return 1'b0;
        endcase
    endfunction

    task automatic runBranch(input opcode_t op);
        logic [31:0] rnd;
        logic        taken;
        rnd = $random(seed);
        taken = branchExpected(op, rnd[0], rnd[1], rnd[2]);
        fetchPhase(op, 6'h00, 1'b0, rnd[0], rnd[1], rnd[2]);
        nextCycle();
        compareBit("pcWrite", pcWrite, 1'b0);
        compareAluOp(aluOp, aluCompare);
        compareAluSrcA(aluSrcA, srcARegA);
        compareAluSrcB(aluSrcB, srcBRegB);
        if (taken) begin
            nextCycle();
            compareBit("pcWrite", pcWrite, 1'b1);
            comparePcSource(pcSource, pcBranchTarget);
        end
    endtask

    task automatic runJump();
        fetchPhase(`OP_J, 6'h00, 1'b0, 1'b0, 1'b0, 1'b0);
        nextCycle();
        compareBit("pcWrite", pcWrite, 1'b1);
        comparePcSource(pcSource, pcJumpTarget);
        compareBit("regWrite", regWrite, 1'b0);
    endtask

    task automatic runJal();
        fetchPhase(`OP_JAL, 6'h00, 1'b0, 1'b0, 1'b0, 1'b0);
        nextCycle();
        compareBit("aluOutWrite", aluOutWrite, 1'b1);
        compareBit("pcWrite", pcWrite, 1'b0);
        compareBit("regWrite", regWrite, 1'b0);
        nextCycle();
        compareBit("pcWrite", pcWrite, 1'b1);
        comparePcSource(pcSource, pcJumpTarget);
        compareBit("regWrite", regWrite, 1'b1);
        compareRegDst(regDst, dstRa);
        compareRegData(regDataSrc, dataAluOut);
    endtask

    task automatic runLoad();
        fetchPhase(`OP_LW, 6'h00, 1'b0, 1'b0, 1'b0, 1'b0);
        nextCycle();
        compareBit("aluOutWrite", aluOutWrite, 1'b1);
        compareAluOp(aluOp, aluAdd);
        compareAluSrcA(aluSrcA, srcARegA);
        compareAluSrcB(aluSrcB, srcBImm);
        repeat (`MEM_WAIT) begin
            nextCycle();
            compareMemAddr(memAddrSrc, memAluOut);
            compareBit("mdrWrite", mdrWrite, 1'b0);
        end
        nextCycle();
        compareBit("mdrWrite", mdrWrite, 1'b1);
        nextCycle();
        compareBit("regWrite", regWrite, 1'b1);
        compareRegDst(regDst, dstRt);
        compareRegData(regDataSrc, dataMdr);
    endtask

    task automatic runStore();
        fetchPhase(`OP_SW, 6'h00, 1'b0, 1'b0, 1'b0, 1'b0);
        nextCycle();
        compareBit("memWrite", memWrite, 1'b0);
        compareBit("aluOutWrite", aluOutWrite, 1'b1);
        compareAluOp(aluOp, aluAdd);
        compareAluSrcA(aluSrcA, srcARegA);
        compareAluSrcB(aluSrcB, srcBImm);
        nextCycle();
        compareBit("memWrite", memWrite, 1'b1);
        compareMemAddr(memAddrSrc, memAluOut);
        compareBit("regWrite", regWrite, 1'b0);
    endtask

    initial begin
        Clock = 1'b0;
        rstN = 1'b0;
        opcode = '0;
        funct = '0;
        overflow = 1'b0;
        equal = 1'b0;
        greater = 1'b0;
        less = 1'b0;
        errorCount = 0;
        checkCount = 0;
        cycleCount = 0;
        seed = 26742;

        @(negedge Clock);
        resetOutputsIdle();
        repeat (2) @(posedge Clock);
        #2;
        rstN = 1'b1;
        @(negedge Clock);
        resetOutputsIdle();
        // Stack pointer write
        nextCycle();
        compareBit("regWrite", regWrite, 1'b1);
        compareRegDst(regDst, dstSp);
        compareRegData(regDataSrc, dataStackInit);

        runArith(`OP_RTYPE, `FN_ADD, 1'b0);
        runArith(`OP_RTYPE, `FN_SUB, 1'b0);
        runArith(`OP_RTYPE, `FN_AND, 1'b0);
        runArith(`OP_RTYPE, `FN_SLT, 1'b0);
        runArith(`OP_ADDI, 6'h00, 1'b0);
        runArith(`OP_ADDIU, 6'h00, 1'b0);
        // and and addiu ignore the overflow flag
        runArith(`OP_RTYPE, `FN_AND, 1'b1);
        runArith(`OP_ADDIU, 6'h00, 1'b1);
        runOverflow(`OP_RTYPE, `FN_ADD);
        runOverflow(`OP_RTYPE, `FN_SUB);
        runOverflow(`OP_ADDI, 6'h00);
        runUndefined(6'h3f, 6'h00);
        runUndefined(`OP_RTYPE, 6'h3f);
        repeat (4) begin
            runBranch(`OP_BEQ);
            runBranch(`OP_BNE);
            runBranch(`OP_BLE);
            runBranch(`OP_BGT);
        end
        runJump();
        runJal();
        runLoad();
        runStore();
        nextCycle();
        checkFetch();

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/controlUnit_properties.sv ====
// Control output assertions
`timescale 1ns/1ps
`default_nettype none

module controlUnitProps (
    input wire logic Clock,
    input wire logic rstN,
    input wire logic memWrite,
    input wire logic mdrWrite,
    input wire logic irWrite,
    input wire logic pcWrite,
    input wire logic regWrite
);

    memNotWithMdr: assert property (
        @(posedge Clock) disable iff (!rstN) !(memWrite && mdrWrite)
    ) else $error("memWrite and mdrWrite active together");

    irWriteSingle: assert property (
        @(posedge Clock) disable iff (!rstN) irWrite |=> !irWrite
    ) else $error("irWrite held longer than one cycle");

    // No architectural writes while held in reset
    quietInReset: assert property (
        @(posedge Clock) !rstN |-> !(pcWrite || regWrite)
    ) else $error("pcWrite or regWrite active during reset");

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hdl
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/instrDecoder.sv
hdl/mainSequencer.sv
hdl/exceptionSequencer.sv
hdl/controlUnit.sv
test/controlUnit_properties.sv
test/controlUnitTb.sv
